//--- source/frontend_pkg.sv
// ----------------------------------------------------------
// Shared definitions for the radio front-end control block
// Address map, register field layouts and decode enums
// ----------------------------------------------------------
package frontend_pkg;

  localparam int num_chans   = 2;
  localparam int addr_w      = 8;
  localparam int data_w      = 32;
  localparam int fe_ctrl_lsb = 10;
  localparam int chan_stride = 2;
  localparam int chan_idx_w  = (num_chans > 1) ? $clog2(num_chans) : 1;
  localparam int pps_cnt_w   = 8;
  // Position of the PPS count inside the status word
  localparam int stat_cnt_lsb = 8;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;

  // Later channels sit chan_stride above these channel 0 addresses
  typedef enum logic [addr_w-1:0] {
    reg_status  = 8'h04,
    reg_misc    = 8'h08,
    reg_fe_ctrl = 8'h10,
    reg_bandsel = 8'h11
  } reg_addr_e;

  typedef enum logic [1:0] {
    sel_none,
    sel_fe,
    sel_band
  } chan_sel_e;

  // ----------------------------------------------------------
  // Register fields with the most significant member first
  // ----------------------------------------------------------
  typedef struct packed {
    logic led_txrx_tx;
    logic led_txrx_rx;
    logic led_rx;
    logic vcrx_v2;
    logic vcrx_v1;
    logic vctxrx_v2;
    logic vctxrx_v1;
    logic tx_enable_b;
    logic tx_enable_a;
  } fe_ctrl_t;

  // rx_a sits in bits 2:0
  typedef struct packed {
    logic [1:0] rx_c;
    logic [1:0] rx_b;
    logic [2:0] rx_a;
  } bandsel_t;

  typedef struct packed {
    logic [2:0] tx_bandsel;
    logic       mimo;
    logic [1:0] pps_select;
  } misc_t;

  typedef struct packed {
    logic plllck;
    logic is_10meg;
    logic is_pps;
    logic reflck;
  } ref_status_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
    logic  stb;
  } set_bus_t;

  function automatic addr_t chan_fe_addr(input int chan);
    return addr_t'(int'(reg_fe_ctrl) + chan * chan_stride);
  endfunction

  function automatic addr_t chan_band_addr(input int chan);
    return addr_t'(int'(reg_bandsel) + chan * chan_stride);
  endfunction

endpackage

//--- source/setting_decoder.sv
// ----------------------------------------------------------
// Settings bus decoder
// Per-channel load strobes and the shared misc register
// ----------------------------------------------------------
`timescale 1ns/1ns

module setting_decoder (
  input  logic                                bus_clk,
  input  logic                                arst_n,
  input  frontend_pkg::set_bus_t              set_bus,
  output logic [frontend_pkg::num_chans-1:0]  fe_wr,
  output logic [frontend_pkg::num_chans-1:0]  band_wr,
  output frontend_pkg::data_t                 wr_data,
  output frontend_pkg::misc_t                 misc
);

  logic [frontend_pkg::chan_idx_w-1:0] chan_idx;
  frontend_pkg::chan_sel_e             kind;

  // Which channel and which of its registers the address hits
  always_comb begin
    chan_idx = '0;
    kind     = frontend_pkg::sel_none;
    for (int c = 0; c < frontend_pkg::num_chans; c++) begin
      if (set_bus.addr == frontend_pkg::chan_fe_addr(c)) begin
        chan_idx = c[frontend_pkg::chan_idx_w-1:0];
        kind     = frontend_pkg::sel_fe;
      end else if (set_bus.addr == frontend_pkg::chan_band_addr(c)) begin
        chan_idx = c[frontend_pkg::chan_idx_w-1:0];
        kind     = frontend_pkg::sel_band;
      end
    end
  end

  // One strobe per mapped write, loaded on the same edge
  always_comb begin
    fe_wr   = '0;
    band_wr = '0;
    if (set_bus.stb) begin
      case (kind)
        frontend_pkg::sel_fe:   fe_wr[chan_idx]   = 1'b1;
        frontend_pkg::sel_band: band_wr[chan_idx] = 1'b1;
        default: ;
      endcase
    end
  end

  assign wr_data = set_bus.data;

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      misc <= '0;
    end else if (set_bus.stb &&
                 set_bus.addr == frontend_pkg::addr_t'(frontend_pkg::reg_misc)) begin
      misc <= frontend_pkg::misc_t'(set_bus.data[$bits(frontend_pkg::misc_t)-1:0]);
    end
  end

endmodule

//--- source/channel_ctrl.sv
// ----------------------------------------------------------
// Per-channel front-end control
// Holds TX enables, antenna selects, LEDs and band selects
// ----------------------------------------------------------
`timescale 1ns/1ns

module channel_ctrl (
  input  logic                   bus_clk,
  input  logic                   arst_n,
  input  logic                   fe_wr,
  input  logic                   band_wr,
  input  frontend_pkg::data_t    wr_data,
  output frontend_pkg::fe_ctrl_t fe,
  output frontend_pkg::bandsel_t bandsel
);

  frontend_pkg::fe_ctrl_t fe_field;
  frontend_pkg::bandsel_t band_field;

  // Field extraction from the settings word
  assign fe_field = frontend_pkg::fe_ctrl_t'(
    wr_data[frontend_pkg::fe_ctrl_lsb +: $bits(frontend_pkg::fe_ctrl_t)]);
  assign band_field = frontend_pkg::bandsel_t'(
    wr_data[$bits(frontend_pkg::bandsel_t)-1:0]);

  // ----------------------------------------------------------
  // Front-end register
  // ----------------------------------------------------------
  // Drives this channel's pins directly
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      fe <= '0;
    end else if (fe_wr) begin
      fe <= fe_field;
    end
  end

  // ----------------------------------------------------------
  // Band-select register
  // ----------------------------------------------------------
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      bandsel <= '0;
    end else if (band_wr) begin
      bandsel <= band_field;
    end
  end

endmodule

//--- source/ref_status_sync.sv
// ----------------------------------------------------------
// Reference status synchronizer
// Brings PPS and TCXO status into bus_clk, counts PPS edges
// ----------------------------------------------------------
`timescale 1ns/1ns

module ref_status_sync (
  input  logic                                bus_clk,
  input  logic                                arst_n,
  input  logic                                pps,
  input  frontend_pkg::ref_status_t           tcxo_status,
  output frontend_pkg::ref_status_t           status,
  output logic [frontend_pkg::pps_cnt_w-1:0]  pps_count
);

  localparam int sync_w = $bits(frontend_pkg::ref_status_t) + 1;

  // PPS travels in the top bit next to the status bits
  logic [sync_w-1:0] sync_meta;
  logic [sync_w-1:0] sync_q;
  logic              pps_prev;
  logic              pps_rise;

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_meta <= '0;
      sync_q    <= '0;
      pps_prev  <= 1'b0;
    end else begin
      sync_meta <= {pps, tcxo_status};
      sync_q    <= sync_meta;
      pps_prev  <= sync_q[sync_w-1];
    end
  end

  assign status   = frontend_pkg::ref_status_t'(sync_q[sync_w-2:0]);
  assign pps_rise = sync_q[sync_w-1] & ~pps_prev;

  // Wraps at 256
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      pps_count <= '0;
    end else if (pps_rise) begin
      pps_count <= pps_count + 1'b1;
    end
  end

endmodule

//--- source/readback_mux.sv
// ----------------------------------------------------------
// Registered readback of channel, misc and status registers
// ----------------------------------------------------------
`timescale 1ns/1ns

module readback_mux (
  input  logic                                                  bus_clk,
  input  logic                                                  arst_n,
  input  frontend_pkg::addr_t                                   rb_addr,
  input  frontend_pkg::fe_ctrl_t [frontend_pkg::num_chans-1:0]  fe,
  input  frontend_pkg::bandsel_t [frontend_pkg::num_chans-1:0]  bandsel,
  input  frontend_pkg::misc_t                                   misc,
  input  frontend_pkg::ref_status_t                             status,
  input  logic [frontend_pkg::pps_cnt_w-1:0]                    pps_count,
  output frontend_pkg::data_t                                   rb_data
);

  frontend_pkg::data_t rb_next;

  // Each field returns at the bit position it was written from
  always_comb begin
    rb_next = '0;
    if (rb_addr == frontend_pkg::addr_t'(frontend_pkg::reg_status)) begin
      rb_next[$bits(frontend_pkg::ref_status_t)-1:0] = status;
      rb_next[frontend_pkg::stat_cnt_lsb +: frontend_pkg::pps_cnt_w] = pps_count;
    end
    if (rb_addr == frontend_pkg::addr_t'(frontend_pkg::reg_misc)) begin
      rb_next[$bits(frontend_pkg::misc_t)-1:0] = misc;
    end
    for (int c = 0; c < frontend_pkg::num_chans; c++) begin
      if (rb_addr == frontend_pkg::chan_fe_addr(c)) begin
        rb_next[frontend_pkg::fe_ctrl_lsb +: $bits(frontend_pkg::fe_ctrl_t)] = fe[c];
      end
      if (rb_addr == frontend_pkg::chan_band_addr(c)) begin
        rb_next[$bits(frontend_pkg::bandsel_t)-1:0] = bandsel[c];
      end
    end
  end

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      rb_data <= '0;
    end else begin
      rb_data <= rb_next;
    end
  end

endmodule

//--- source/radio_frontend_ctrl.sv
// ----------------------------------------------------------
// Radio front-end control top level
// Settings bus to RF board pins, plus reference status path
// ----------------------------------------------------------
`timescale 1ns/1ns

module radio_frontend_ctrl (
  input  logic                                                  bus_clk,
  input  logic                                                  arst_n,
  input  frontend_pkg::set_bus_t                                set_bus,
  input  frontend_pkg::addr_t                                   rb_addr,
  output frontend_pkg::data_t                                   rb_data,
  input  logic                                                  pps,
  input  frontend_pkg::ref_status_t                             tcxo_status,
  output frontend_pkg::fe_ctrl_t [frontend_pkg::num_chans-1:0]  fe_pins,
  output frontend_pkg::bandsel_t [frontend_pkg::num_chans-1:0]  bandsel_pins,
  output logic [2:0]                                            tx_bandsel,
  output logic [1:0]                                            pps_select,
  output logic                                                  mimo
);

  logic [frontend_pkg::num_chans-1:0] fe_wr;
  logic [frontend_pkg::num_chans-1:0] band_wr;
  frontend_pkg::data_t                wr_data;
  frontend_pkg::misc_t                misc;
  frontend_pkg::ref_status_t          status;
  logic [frontend_pkg::pps_cnt_w-1:0] pps_count;

  // ----------------------------------------------------------
  // Settings decode and shared misc register
  // ----------------------------------------------------------
  setting_decoder u_decoder (
    .bus_clk (bus_clk),
    .arst_n  (arst_n),
    .set_bus (set_bus),
    .fe_wr   (fe_wr),
    .band_wr (band_wr),
    .wr_data (wr_data),
    .misc    (misc)
  );

  assign tx_bandsel = misc.tx_bandsel;
  assign pps_select = misc.pps_select;
  assign mimo       = misc.mimo;

  // ----------------------------------------------------------
  // One control block per RF channel
  // ----------------------------------------------------------
  for (genvar c = 0; c < frontend_pkg::num_chans; c++) begin : g_chan
    channel_ctrl u_chan (
      .bus_clk (bus_clk),
      .arst_n  (arst_n),
      .fe_wr   (fe_wr[c]),
      .band_wr (band_wr[c]),
      .wr_data (wr_data),
      .fe      (fe_pins[c]),
      .bandsel (bandsel_pins[c])
    );
  end

  ref_status_sync u_status (
    .bus_clk     (bus_clk),
    .arst_n      (arst_n),
    .pps         (pps),
    .tcxo_status (tcxo_status),
    .status      (status),
    .pps_count   (pps_count)
  );

  readback_mux u_readback (
    .bus_clk   (bus_clk),
    .arst_n    (arst_n),
    .rb_addr   (rb_addr),
    .fe        (fe_pins),
    .bandsel   (bandsel_pins),
    .misc      (misc),
    .status    (status),
    .pps_count (pps_count),
    .rb_data   (rb_data)
  );

endmodule

//--- verification/radio_frontend_chk.sv
// ----------------------------------------------------------
// Assertions on write effect, reset values and readback
// ----------------------------------------------------------
`timescale 1ns/1ns

module radio_frontend_chk (
  input logic                                                  bus_clk,
  input logic                                                  arst_n,
  input frontend_pkg::set_bus_t                                set_bus,
  input frontend_pkg::data_t                                   rb_data,
  input frontend_pkg::fe_ctrl_t [frontend_pkg::num_chans-1:0]  fe_pins,
  input frontend_pkg::bandsel_t [frontend_pkg::num_chans-1:0]  bandsel_pins,
  input frontend_pkg::misc_t                                   misc
);

  // A strobed channel write shows on the pins one cycle later
  for (genvar c = 0; c < frontend_pkg::num_chans; c++) begin : g_chan
    localparam frontend_pkg::addr_t fe_a = frontend_pkg::addr_t'(
      int'(frontend_pkg::reg_fe_ctrl) + c * frontend_pkg::chan_stride);
    localparam frontend_pkg::addr_t band_a = frontend_pkg::addr_t'(
      int'(frontend_pkg::reg_bandsel) + c * frontend_pkg::chan_stride);

    a_fe_write: assert property (@(posedge bus_clk) disable iff (!arst_n)
      set_bus.stb && set_bus.addr == fe_a |=> fe_pins[c] == $past(set_bus.data[18:10]))
      else $error("fe_pins[%0d] did not load the written word", c);

    a_band_write: assert property (@(posedge bus_clk) disable iff (!arst_n)
      set_bus.stb && set_bus.addr == band_a |=> bandsel_pins[c] == $past(set_bus.data[6:0]))
      else $error("bandsel_pins[%0d] did not load the written word", c);
  end

  a_reset_zero: assert property (@(posedge bus_clk)
    !arst_n |-> fe_pins == '0 && bandsel_pins == '0 && misc == '0 && rb_data == '0)
    else $error("Outputs are not zero while in reset");

  a_rb_known: assert property (@(posedge bus_clk) disable iff (!arst_n)
    !$isunknown(rb_data))
    else $error("rb_data has unknown bits");

endmodule

bind radio_frontend_ctrl radio_frontend_chk u_chk (.*);

//--- verification/tb_radio_frontend_ctrl.sv
// ----------------------------------------------------------
// Testbench for the radio front-end control block
// Table of settings writes and readbacks, then a PPS test
// ----------------------------------------------------------
`timescale 1ns/1ns

module tb_radio_frontend_ctrl;

  localparam int nch          = frontend_pkg::num_chans;
  localparam int num_rows     = 4 * nch + 12;
  localparam int rst_cycles   = 8;
  localparam int num_pulses   = 5;
  localparam int pps_test_len = 48;
  localparam int cycle_limit  = rst_cycles + 2 * num_rows + pps_test_len;

  typedef struct packed {
    logic                is_wr;
    frontend_pkg::addr_t addr;
    frontend_pkg::data_t data;
    frontend_pkg::data_t exp_rb;
  } row_t;

  logic                             bus_clk;
  logic                             arst_n;
  frontend_pkg::set_bus_t           set_bus;
  frontend_pkg::addr_t              rb_addr;
  frontend_pkg::data_t              rb_data;
  logic                             pps;
  frontend_pkg::ref_status_t        tcxo_status;
  frontend_pkg::fe_ctrl_t [nch-1:0] fe_pins;
  frontend_pkg::bandsel_t [nch-1:0] bandsel_pins;
  logic [2:0]                       tx_bandsel;
  logic [1:0]                       pps_select;
  logic                             mimo;

  row_t        rows [num_rows];
  int          n_rows;
  int          error_count;
  int          check_count;
  int          cycle_cnt;
  logic [31:0] lfsr;

  // Expected register contents
  frontend_pkg::fe_ctrl_t m_fe [nch];
  frontend_pkg::bandsel_t m_band [nch];
  frontend_pkg::misc_t    m_misc;

  radio_frontend_ctrl DUT (.*);

  initial begin
    bus_clk = 1'b0;
    forever #10 bus_clk = ~bus_clk;
  end

  always @(posedge bus_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic frontend_pkg::data_t random_word();
    frontend_pkg::data_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[30:0], lfsr[0]};
    end
    return w;
  endfunction

  function automatic frontend_pkg::addr_t fe_addr(input int c);
    return frontend_pkg::addr_t'(int'(frontend_pkg::reg_fe_ctrl) + c * frontend_pkg::chan_stride);
  endfunction

  function automatic frontend_pkg::addr_t band_addr(input int c);
    return frontend_pkg::addr_t'(int'(frontend_pkg::reg_bandsel) + c * frontend_pkg::chan_stride);
  endfunction

  // ----------------------------------------------------------
  // Reference model from the register field rules
  // ----------------------------------------------------------
  function automatic void update_model(input frontend_pkg::addr_t a,
                                       input frontend_pkg::data_t d);
    for (int c = 0; c < nch; c++) begin
      if (a == fe_addr(c)) m_fe[c] = d[18:10];
      if (a == band_addr(c)) m_band[c] = d[6:0];
    end
    if (a == frontend_pkg::addr_t'(frontend_pkg::reg_misc)) m_misc = d[5:0];
  endfunction

  // PPS and TCXO stay idle during the table so status reads zero
  function automatic frontend_pkg::data_t expected_read(input frontend_pkg::addr_t a);
    frontend_pkg::data_t r;
    r = '0;
    for (int c = 0; c < nch; c++) begin
      if (a == fe_addr(c)) r[18:10] = m_fe[c];
      if (a == band_addr(c)) r[6:0] = m_band[c];
    end
    if (a == frontend_pkg::addr_t'(frontend_pkg::reg_misc)) r[5:0] = m_misc;
    return r;
  endfunction

  task automatic clear_model();
    for (int c = 0; c < nch; c++) begin
      m_fe[c]   = '0;
      m_band[c] = '0;
    end
    m_misc = '0;
  endtask

  task automatic add_row(input logic wr, input frontend_pkg::addr_t a,
                         input frontend_pkg::data_t d);
    rows[n_rows].is_wr  = wr;
    rows[n_rows].addr   = a;
    rows[n_rows].data   = d;
    rows[n_rows].exp_rb = wr ? '0 : expected_read(a);
    if (wr) update_model(a, d);
    n_rows++;
  endtask

  task automatic build_table();
    frontend_pkg::addr_t misc_a;
    frontend_pkg::addr_t stat_a;
    misc_a = frontend_pkg::addr_t'(frontend_pkg::reg_misc);
    stat_a = frontend_pkg::addr_t'(frontend_pkg::reg_status);
    for (int c = 0; c < nch; c++) begin
      add_row(1'b1, fe_addr(c), random_word());
      add_row(1'b0, fe_addr(c), '0);
      add_row(1'b1, band_addr(c), random_word());
      add_row(1'b0, band_addr(c), '0);
    end
    add_row(1'b1, misc_a, random_word());
    add_row(1'b0, misc_a, '0);
    // Read-only and unmapped addresses
    add_row(1'b1, stat_a, random_word());
    add_row(1'b0, stat_a, '0);
    add_row(1'b1, 8'h14, random_word());
    add_row(1'b1, 8'hff, random_word());
    add_row(1'b0, 8'h14, '0);
    add_row(1'b0, 8'h00, '0);
    add_row(1'b0, 8'hff, '0);
    add_row(1'b0, fe_addr(0), '0);
    add_row(1'b0, band_addr(nch - 1), '0);
    add_row(1'b0, misc_a, '0);
  endtask

  task automatic check_value(input frontend_pkg::data_t got, input frontend_pkg::data_t exp,
                             input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_pins();
    for (int c = 0; c < nch; c++) begin
      check_value(32'(fe_pins[c]), 32'(m_fe[c]), $sformatf("fe_pins[%0d]", c));
      check_value(32'(bandsel_pins[c]), 32'(m_band[c]), $sformatf("bandsel_pins[%0d]", c));
    end
    check_value(32'({tx_bandsel, mimo, pps_select}), 32'(m_misc), "misc pins");
  endtask

  task automatic apply_row(input row_t r);
    @(posedge bus_clk);
    if (r.is_wr) begin
      set_bus.addr <= r.addr;
      set_bus.data <= r.data;
      set_bus.stb  <= 1'b1;
      @(posedge bus_clk);
      set_bus.stb <= 1'b0;
      update_model(r.addr, r.data);
      @(negedge bus_clk);
    end else begin
      rb_addr <= r.addr;
      @(posedge bus_clk);
      @(negedge bus_clk);
      check_value(rb_data, r.exp_rb, $sformatf("rb_data at address %h", r.addr));
    end
    check_pins();
  endtask

  // ----------------------------------------------------------
  // PPS counting and TCXO status path
  // ----------------------------------------------------------
  task automatic run_pps_test();
    for (int i = 0; i < num_pulses; i++) begin
      @(posedge bus_clk);
      pps <= 1'b1;
      repeat (3) @(posedge bus_clk);
      pps <= 1'b0;
      repeat (2) @(posedge bus_clk);
    end
    rb_addr <= frontend_pkg::addr_t'(frontend_pkg::reg_status);
    repeat (4) @(posedge bus_clk);
    @(negedge bus_clk);
    check_value(rb_data, {16'h0, 8'(num_pulses), 8'h00}, "PPS count readback");
    @(posedge bus_clk);
    tcxo_status <= 4'hb;
    repeat (3) @(posedge bus_clk);
    @(negedge bus_clk);
    check_value(rb_data, {16'h0, 8'(num_pulses), 4'h0, 4'hb}, "TCXO status readback");
  endtask

  initial begin
    arst_n      <= 1'b0;
    set_bus     <= '0;
    rb_addr     <= '0;
    pps         <= 1'b0;
    tcxo_status <= '0;
    lfsr = 32'hc52e;
    clear_model();
    build_table();
    clear_model();
    repeat (rst_cycles) @(posedge bus_clk);
    arst_n <= 1'b1;
    @(negedge bus_clk);
    check_pins();
    check_value(rb_data, '0, "rb_data after reset");
    for (int i = 0; i < num_rows; i++) begin
      apply_row(rows[i]);
    end
    run_pps_test();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- radio_frontend_ctrl.f
source/frontend_pkg.sv
source/setting_decoder.sv
source/channel_ctrl.sv
source/ref_status_sync.sv
source/readback_mux.sv
source/radio_frontend_ctrl.sv
verification/radio_frontend_chk.sv
verification/tb_radio_frontend_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the radio front-end control testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
  --top-module tb_radio_frontend_ctrl \
  -f radio_frontend_ctrl.f \
  && ./obj_dir/Vtb_radio_frontend_ctrl | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }
grep -q "Simulation finished: PASS" sim.log \
  && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }
